// ==== Bender.yml ====
package:
  name: reduceNode

sources:
  - files:
      - hw/reducePkg.sv
      - hw/flitDecode.sv
      - hw/combineAlu.sv
      - hw/reductionTable.sv
      - hw/resultFormat.sv
      - hw/nodeRegs.sv
      - hw/reduceNode.sv
  - target: test
    files:
      - verif/reduceNodeTb.sv

// ==== hw/combineAlu.sv ====
`timescale 1ns/1ps

module combineAlu
  import reducePkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic [PayloadWidth-1:0] aIn,      // accumulator
  input  logic [PayloadWidth-1:0] bIn,      // new child payload
  input  combineE                 fn,
  input  logic                    issue,
  input  logic [SlotBits-1:0]     slotIn,
  output logic [PayloadWidth-1:0] result,
  output logic                    resultValid,
  output logic [SlotBits-1:0]     slotOut
);

  logic [PayloadWidth-1:0] fnOut;
  logic [PayloadWidth-1:0] resPipe [AluLatency];
  logic [SlotBits-1:0]     slotPipe [AluLatency];
  logic [AluLatency-1:0]   vldPipe;

  // integer combine, max and min are signed
  always_comb begin
    case (fn)
      cmbSum:  fnOut = aIn + bIn;
      cmbMax:  fnOut = ($signed(aIn) > $signed(bIn)) ? aIn : bIn;
      cmbMin:  fnOut = ($signed(aIn) < $signed(bIn)) ? aIn : bIn;
      default: fnOut = aIn | bIn;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vldPipe <= '0;
    end else begin
      vldPipe <= {vldPipe[AluLatency-2:0], issue};  // shift in one per cycle
    end
  end

  // result and slot tag ride alongside the valid bits
  always_ff @(posedge clk) begin
    resPipe[0]  <= fnOut;
    slotPipe[0] <= slotIn;
    for (int i = 1; i < AluLatency; i++) begin
      resPipe[i]  <= resPipe[i-1];
      slotPipe[i] <= slotPipe[i-1];
    end
  end

  assign result      = resPipe[AluLatency-1];
  assign slotOut     = slotPipe[AluLatency-1];
  assign resultValid = vldPipe[AluLatency-1];

endmodule

// ==== hw/flitDecode.sv ====
`timescale 1ns/1ps

module flitDecode
  import reducePkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  flitT                  inFlit,
  input  logic [ChildWidth-1:0] inChildren,
  input  logic                  inValid,
  output logic                  inReady,
  output decodedT               dec,
  output logic                  decValid,
  input  logic                  decReady
);

  headerT hdrIn;
  logic   running;  // low through reset, high from the first cycle after
  logic   take;

  // header is everything above the payload
  assign hdrIn = headerT'(inFlit[FlitWidth-1:PayloadWidth]);

  // one entry, refill while it drains
  assign inReady = running && (!decValid || decReady);
  assign take    = inValid && inReady;

  always_ff @(posedge clk) begin
    if (rst) begin
      running  <= 1'b0;
      decValid <= 1'b0;
    end else begin
      running <= 1'b1;
      if (take) begin
        decValid <= 1'b1;
      end else if (decReady) begin
        decValid <= 1'b0;  // consumed, nothing new
      end
    end
  end

  // decoded record
  always_ff @(posedge clk) begin
    if (take) begin
      dec.hdr      <= hdrIn;
      dec.slot     <= inFlit.tag[SlotBits-1:0];  // low tag bits pick the slot
      dec.children <= inChildren;
      dec.payload  <= inFlit.payload;
      // op class 11xx on a valid flit
      dec.isReduction <= inFlit.valid && (inFlit.op[3:2] == 2'b11);
    end
  end

endmodule

// ==== hw/nodeRegs.sv ====
`timescale 1ns/1ps

module nodeRegs
  import reducePkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic [AxiAddrWidth-1:0]   sAxiAwAddr,
  input  logic                      sAxiAwValid,
  output logic                      sAxiAwReady,
  input  logic [AxiDataWidth-1:0]   sAxiWData,
  input  logic [AxiDataWidth/8-1:0] sAxiWStrb,
  input  logic                      sAxiWValid,
  output logic                      sAxiWReady,
  output logic [1:0]                sAxiBResp,
  output logic                      sAxiBValid,
  input  logic                      sAxiBReady,
  input  logic [AxiAddrWidth-1:0]   sAxiArAddr,
  input  logic                      sAxiArValid,
  output logic                      sAxiArReady,
  output logic [AxiDataWidth-1:0]   sAxiRData,
  output logic [1:0]                sAxiRResp,
  output logic                      sAxiRValid,
  input  logic                      sAxiRReady,
  input  logic                      completedPulse,
  input  logic                      droppedPulse,
  output coordT                     nodeCoord
);

  logic                      awHave, wHave;  // halves of a write collected
  logic [AxiAddrWidth-1:0]   awAddrQ;
  logic [AxiDataWidth-1:0]   wDataQ;
  logic [AxiDataWidth/8-1:0] wStrbQ;
  logic [CountWidth-1:0]     completedCnt, droppedCnt;
  logic                      doWrite;

  assign sAxiAwReady = !awHave && !sAxiBValid;
  assign sAxiWReady  = !wHave && !sAxiBValid;
  assign sAxiArReady = !sAxiRValid;
  assign doWrite     = awHave && wHave;

  always_ff @(posedge clk) begin
    if (rst) begin
      {awHave, wHave, sAxiBValid, sAxiRValid} <= '0;
      nodeCoord    <= '0;
      completedCnt <= '0;
      droppedCnt   <= '0;
    end else begin
      if (sAxiAwValid && sAxiAwReady) awHave <= 1'b1;
      if (sAxiWValid && sAxiWReady) wHave <= 1'b1;
      if (doWrite) begin
        {awHave, wHave} <= 2'b00;
        sAxiBValid      <= 1'b1;
        if (awAddrQ == AddrCoord) begin  // only writable register
          if (wStrbQ[0]) nodeCoord[7:0] <= wDataQ[7:0];
          if (wStrbQ[1]) nodeCoord[8]   <= wDataQ[8];
        end
      end else if (sAxiBReady) begin
        sAxiBValid <= 1'b0;
      end
      if (sAxiArValid && sAxiArReady) begin
        sAxiRValid <= 1'b1;
      end else if (sAxiRReady) begin
        sAxiRValid <= 1'b0;
      end
      if (completedPulse && completedCnt != '1) completedCnt <= completedCnt + 1'b1;  // saturate
      if (droppedPulse && droppedCnt != '1) droppedCnt <= droppedCnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (sAxiAwValid && sAxiAwReady) awAddrQ <= sAxiAwAddr;
    if (sAxiWValid && sAxiWReady) begin
      wDataQ <= sAxiWData;
      wStrbQ <= sAxiWStrb;
    end
    if (doWrite) sAxiBResp <= (awAddrQ == AddrCoord) ? RespOkay : RespSlvErr;
    if (sAxiArValid && sAxiArReady) begin
      sAxiRResp <= RespOkay;
      case (sAxiArAddr)
        AddrCoord:     sAxiRData <= AxiDataWidth'(nodeCoord);
        AddrCompleted: sAxiRData <= AxiDataWidth'(completedCnt);
        AddrDropped:   sAxiRData <= AxiDataWidth'(droppedCnt);
        default: begin
          sAxiRData <= '0;  // unmapped
          sAxiRResp <= RespSlvErr;
        end
      endcase
    end
  end

endmodule

// ==== hw/reduceNode.sv ====
`timescale 1ns/1ps

module reduceNode
  import reducePkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  flitT                      inFlit,
  input  logic [ChildWidth-1:0]     inChildren,
  input  logic                      inValid,
  output logic                      inReady,
  output flitT                      outFlit,
  output logic                      outValid,
  input  logic                      outReady,
  input  logic [AxiAddrWidth-1:0]   sAxiAwAddr,
  input  logic                      sAxiAwValid,
  output logic                      sAxiAwReady,
  input  logic [AxiDataWidth-1:0]   sAxiWData,
  input  logic [AxiDataWidth/8-1:0] sAxiWStrb,
  input  logic                      sAxiWValid,
  output logic                      sAxiWReady,
  output logic [1:0]                sAxiBResp,
  output logic                      sAxiBValid,
  input  logic                      sAxiBReady,
  input  logic [AxiAddrWidth-1:0]   sAxiArAddr,
  input  logic                      sAxiArValid,
  output logic                      sAxiArReady,
  output logic [AxiDataWidth-1:0]   sAxiRData,
  output logic [1:0]                sAxiRResp,
  output logic                      sAxiRValid,
  input  logic                      sAxiRReady
);

  decodedT  dec;
  logic     decValid, decReady;
  tableOutT doneOut;
  logic     doneValid, doneReady;
  logic     completedPulse, droppedPulse;
  coordT    nodeCoord;

  // decode
  flitDecode decodeI (.clk, .rst, .inFlit, .inChildren, .inValid, .inReady,
                      .dec, .decValid, .decReady);

  // execute
  reductionTable tableI (.clk, .rst, .dec, .decValid, .decReady, .doneOut, .doneValid,
                         .doneReady, .completedPulse, .droppedPulse);

  // result
  resultFormat resultI (.clk, .rst, .doneIn(doneOut), .doneValid, .doneReady, .nodeCoord,
                        .outFlit, .outValid, .outReady);

  nodeRegs regsI (.clk, .rst, .sAxiAwAddr, .sAxiAwValid, .sAxiAwReady, .sAxiWData, .sAxiWStrb,
                  .sAxiWValid, .sAxiWReady, .sAxiBResp, .sAxiBValid, .sAxiBReady, .sAxiArAddr,
                  .sAxiArValid, .sAxiArReady, .sAxiRData, .sAxiRResp, .sAxiRValid, .sAxiRReady,
                  .completedPulse, .droppedPulse, .nodeCoord);

endmodule

// ==== hw/reducePkg.sv ====
package reducePkg;

  localparam int FlitWidth    = 82;
  localparam int PayloadWidth = 32;
  localparam int TableSize    = 8;  // one slot per low tag value
  localparam int SlotBits     = 3;
  localparam int ChildWidth   = 3;
  localparam int AluLatency   = 3;  // combine pipe depth
  localparam int CountWidth   = 16;

  // register slave
  localparam int AxiAddrWidth = 4;
  localparam int AxiDataWidth = 32;
  localparam logic [AxiAddrWidth-1:0] AddrCoord     = 4'h0;
  localparam logic [AxiAddrWidth-1:0] AddrCompleted = 4'h4;
  localparam logic [AxiAddrWidth-1:0] AddrDropped   = 4'h8;
  localparam logic [1:0] RespOkay   = 2'b00;
  localparam logic [1:0] RespSlvErr = 2'b10;

  typedef struct packed {
    logic [2:0] z;
    logic [2:0] y;
    logic [2:0] x;
  } coordT;

  typedef enum logic [1:0] {cmbSum, cmbMax, cmbMin, cmbOr} combineE;

  // top two bits both set marks a reduction
  typedef enum logic [3:0] {
    collAllgather     = 4'b1010,
    collGather        = 4'b1011,
    collReduce        = 4'b1100,
    collLongReduce    = 4'b1101,
    collAllreduce     = 4'b1110,
    collLongAllreduce = 4'b1111
  } collOpE;

  typedef enum logic [1:0] {slotIdle, slotGather, slotCombine, slotDone} slotStateE;

  typedef struct packed {
    logic                    valid;
    coordT                   dst;
    coordT                   src;
    logic [8:0]              rank;
    logic [7:0]              contextId;
    logic [7:0]              tag;
    combineE                 combine;
    collOpE                  op;
    logic [PayloadWidth-1:0] payload;
  } flitT;

  // flit minus payload, same bit order
  typedef struct packed {
    logic       valid;
    coordT      dst;
    coordT      src;
    logic [8:0] rank;
    logic [7:0] contextId;
    logic [7:0] tag;
    combineE    combine;
    collOpE     op;
  } headerT;

  typedef struct packed {
    headerT                  hdr;
    logic [SlotBits-1:0]     slot;
    logic [ChildWidth-1:0]   children;
    logic                    isReduction;
    logic [PayloadWidth-1:0] payload;
  } decodedT;

  typedef struct packed {
    headerT                  hdr;  // first flit of the reduction
    logic [PayloadWidth-1:0] acc;
  } tableOutT;

endpackage

// ==== hw/reductionTable.sv ====
`timescale 1ns/1ps

module reductionTable
  import reducePkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  decodedT  dec,
  input  logic     decValid,
  output logic     decReady,
  output tableOutT doneOut,
  output logic     doneValid,
  input  logic     doneReady,
  output logic     completedPulse,
  output logic     droppedPulse
);

  // per slot storage
  slotStateE               state  [TableSize];
  headerT                  hdrMem [TableSize];
  logic [PayloadWidth-1:0] accMem [TableSize];
  logic [ChildWidth-1:0]   remain [TableSize];  // children still owed

  slotStateE               decState;
  logic                    take;
  logic                    first;    // opens an idle slot
  logic                    issue;    // folds into a gathering slot
  logic                    drop;
  logic                    doneTake;
  logic [SlotBits-1:0]     doneSlot;
  logic [PayloadWidth-1:0] aluResult;
  logic                    aluValid;
  logic [SlotBits-1:0]     aluSlot;

  assign decState = state[dec.slot];

  // stall only a flit aimed at a busy or finished slot
  assign decReady = !dec.isReduction || (decState == slotIdle) || (decState == slotGather);
  assign take     = decValid && decReady;
  assign first    = take && dec.isReduction && (decState == slotIdle);
  assign issue    = take && dec.isReduction && (decState == slotGather);
  assign drop     = take && !dec.isReduction;

  combineAlu aluI (
    .clk         (clk),
    .rst         (rst),
    .aIn         (accMem[dec.slot]),
    .bIn         (dec.payload),
    .fn          (hdrMem[dec.slot].combine),  // function of the first flit
    .issue       (issue),
    .slotIn      (dec.slot),
    .result      (aluResult),
    .resultValid (aluValid),
    .slotOut     (aluSlot)
  );

  // lowest done slot wins, scan downward so the last hit is the lowest
  always_comb begin
    doneValid = 1'b0;
    doneSlot  = '0;
    for (int i = TableSize - 1; i >= 0; i--) begin
      if (state[i] == slotDone) begin
        doneValid = 1'b1;
        doneSlot  = SlotBits'(i);
      end
    end
  end

  assign doneOut.hdr = hdrMem[doneSlot];
  assign doneOut.acc = accMem[doneSlot];
  assign doneTake    = doneValid && doneReady;

  // slot FSM; decode, alu return and release never hit the same slot
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < TableSize; i++) begin
        state[i] <= slotIdle;
      end
      completedPulse <= 1'b0;
      droppedPulse   <= 1'b0;
    end else begin
      completedPulse <= doneTake;
      droppedPulse   <= drop;
      if (first) begin
        // leaf goes straight out
        state[dec.slot] <= (dec.children == '0) ? slotDone : slotGather;
      end else if (issue) begin
        state[dec.slot] <= slotCombine;  // held for the alu latency
      end
      if (aluValid) begin
        state[aluSlot] <= (remain[aluSlot] == ChildWidth'(1)) ? slotDone : slotGather;
      end
      if (doneTake) begin
        state[doneSlot] <= slotIdle;
      end
    end
  end

  // header, accumulator, count
  always_ff @(posedge clk) begin
    if (first) begin
      hdrMem[dec.slot] <= dec.hdr;
      accMem[dec.slot] <= dec.payload;  // first flit seeds the accumulator
      remain[dec.slot] <= dec.children;
    end
    if (aluValid) begin
      accMem[aluSlot] <= aluResult;
      remain[aluSlot] <= remain[aluSlot] - ChildWidth'(1);
    end
  end

endmodule

// ==== hw/resultFormat.sv ====
`timescale 1ns/1ps

module resultFormat
  import reducePkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  tableOutT doneIn,
  input  logic     doneValid,
  output logic     doneReady,
  input  coordT    nodeCoord,
  output flitT     outFlit,
  output logic     outValid,
  input  logic     outReady
);

  tableOutT pend;       // captured done record
  logic     pendValid;
  logic     outLoad;
  flitT     built;

  assign outLoad   = pendValid && (!outValid || outReady);  // out reg free or draining
  assign doneReady = !pendValid || outLoad;

  always_comb begin
    built.valid     = 1'b1;
    built.dst       = pend.hdr.dst;
    built.src       = nodeCoord;  // result leaves from this node
    built.rank      = pend.hdr.rank;
    built.contextId = pend.hdr.contextId;
    built.tag       = pend.hdr.tag;
    built.combine   = pend.hdr.combine;
    built.payload   = pend.acc;
    // long variants continue as gathers
    case (pend.hdr.op)
      collLongReduce:    built.op = collGather;
      collLongAllreduce: built.op = collAllgather;
      default:           built.op = pend.hdr.op;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pendValid <= 1'b0;
      outValid  <= 1'b0;
    end else begin
      if (doneValid && doneReady) begin
        pendValid <= 1'b1;
      end else if (outLoad) begin
        pendValid <= 1'b0;
      end
      if (outLoad) begin
        outValid <= 1'b1;
      end else if (outReady) begin
        outValid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (doneValid && doneReady) pend <= doneIn;
    if (outLoad) outFlit <= built;  // held while outReady is low
  end

endmodule

// ==== reduceNode.f ====
hw/reducePkg.sv
hw/flitDecode.sv
hw/combineAlu.sv
hw/reductionTable.sv
hw/resultFormat.sv
hw/nodeRegs.sv
hw/reduceNode.sv
verif/reduceNodeTb.sv

// ==== verif/reduceNodeTb.sv ====
`timescale 1ns/1ps

module reduceNodeTb
  import reducePkg::*;
();

  localparam int Timeout = 200;  // cycles allowed per wait

  // one reduction per row
  typedef struct {
    logic [7:0] tag;
    combineE    fn;
    collOpE     op;
    int         children;
    coordT      dst;
    string      name;
  } rowT;

  logic                      clk = 1'b0;
  logic                      rst;
  flitT                      inFlit, outFlit;
  logic [ChildWidth-1:0]     inChildren;
  logic                      inValid, inReady, outValid, outReady;
  logic [AxiAddrWidth-1:0]   sAxiAwAddr, sAxiArAddr;
  logic                      sAxiAwValid, sAxiAwReady, sAxiWValid, sAxiWReady;
  logic                      sAxiBValid, sAxiBReady, sAxiArValid, sAxiArReady;
  logic                      sAxiRValid, sAxiRReady;
  logic [AxiDataWidth-1:0]   sAxiWData, sAxiRData;
  logic [AxiDataWidth/8-1:0] sAxiWStrb;
  logic [1:0]                sAxiBResp, sAxiRResp;

  rowT         rows [7];
  logic [31:0] seed = 32'h82e2883e;  // shared by payloads and stall pattern
  coordT       nodeC = coordT'(9'h16b);

  reduceNode reduceNode_i (.*);

  always #4 clk = ~clk;  // 8 ns period

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] randWord();
    seed = lcgNext(seed);
    return seed;
  endfunction

  // reference fold, max and min compare as signed
  function automatic logic [31:0] foldRef(input combineE fn, input logic [31:0] a,
                                          input logic [31:0] b);
    case (fn)
      cmbSum:  return a + b;
      cmbMax:  return ($signed(b) > $signed(a)) ? b : a;
      cmbMin:  return ($signed(b) < $signed(a)) ? b : a;
      default: return a | b;
    endcase
  endfunction

  // result header: source is this node, long ops become gathers
  function automatic flitT expectFor(input flitT f);
    flitT e;
    e = f;
    e.src = nodeC;
    if (f.op == collLongReduce) e.op = collGather;
    else if (f.op == collLongAllreduce) e.op = collAllgather;
    return e;
  endfunction

  function automatic flitT makeFlit(input rowT r, input int idx);
    flitT f;
    f.valid     = 1'b1;
    f.dst       = r.dst;
    f.src       = coordT'(9'(idx * 37));
    f.rank      = 9'(idx * 5 + 1);
    f.contextId = 8'(8'hc0 + idx);
    f.tag       = r.tag;
    f.combine   = r.fn;
    f.op        = r.op;
    f.payload   = randWord();
    return f;
  endfunction

  task automatic stopOnError(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic checkEq(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      stopOnError($sformatf("FAILED %s: expected %0h, actual %0h", name, exp, act));
    end
  endtask

  task automatic checkFlit(input string name, input flitT exp, input flitT got);
    checkEq({name, " valid"}, 64'(exp.valid), 64'(got.valid));
    checkEq({name, " dst"}, 64'(exp.dst), 64'(got.dst));
    checkEq({name, " src"}, 64'(exp.src), 64'(got.src));
    checkEq({name, " rank"}, 64'(exp.rank), 64'(got.rank));
    checkEq({name, " contextId"}, 64'(exp.contextId), 64'(got.contextId));
    checkEq({name, " tag"}, 64'(exp.tag), 64'(got.tag));
    checkEq({name, " combine"}, 64'(exp.combine), 64'(got.combine));
    checkEq({name, " op"}, 64'(exp.op), 64'(got.op));
    checkEq({name, " payload"}, 64'(exp.payload), 64'(got.payload));
  endtask

  // called 1 ns after an edge, returns 1 ns after the accepting edge
  task automatic sendFlit(input flitT f, input logic [ChildWidth-1:0] ch);
    int waited;
    waited = 0;
    inFlit = f;
    inChildren = ch;
    inValid = 1'b1;
    @(negedge clk);
    while (!inReady) begin
      waited++;
      if (waited > Timeout) stopOnError("inReady stayed low, input flit never accepted");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    inValid = 1'b0;
  endtask

  // takes one output flit, idle counts the cycles without a transfer
  task automatic waitResult(input bit stall, output flitT got, output int idle);
    logic [31:0] r;
    bit          hit;
    hit  = 1'b0;
    idle = 0;
    while (!hit) begin
      r = randWord();
      outReady = stall ? r[20] : 1'b1;  // upper bit, low bits cycle short
      @(negedge clk);
      if (outValid && outReady) begin
        hit = 1'b1;
        got = outFlit;
      end else begin
        idle++;
        if (idle > Timeout) stopOnError("no result flit arrived before the timeout");
      end
      @(posedge clk);
      #1;
    end
  endtask

  task automatic expectQuiet(input int cycles);
    outReady = 1'b1;
    repeat (cycles) begin
      @(negedge clk);
      if (outValid) stopOnError("an output flit appeared where none was expected");
    end
    @(posedge clk);
    #1;
  endtask

  task automatic axiWrite(input logic [3:0] addr, input logic [31:0] data,
                          output logic [1:0] resp);
    int   waited;
    logic awGo, wGo;
    waited = 0;
    {sAxiAwAddr, sAxiWData, sAxiWStrb} = {addr, data, 4'hf};
    {sAxiAwValid, sAxiWValid} = 2'b11;
    while (sAxiAwValid || sAxiWValid) begin
      @(negedge clk);
      awGo = sAxiAwValid && sAxiAwReady;
      wGo  = sAxiWValid && sAxiWReady;
      @(posedge clk);
      #1;
      if (awGo) sAxiAwValid = 1'b0;
      if (wGo) sAxiWValid = 1'b0;
      waited++;
      if (waited > Timeout) stopOnError("AXI write address or data not accepted");
    end
    sAxiBReady = 1'b1;
    @(negedge clk);
    while (!sAxiBValid) begin
      waited++;
      if (waited > Timeout) stopOnError("AXI write response never arrived");
      @(negedge clk);
    end
    resp = sAxiBResp;
    @(posedge clk);
    #1;
    sAxiBReady = 1'b0;
  endtask

  task automatic axiRead(input logic [3:0] addr, output logic [31:0] data,
                         output logic [1:0] resp);
    int waited;
    waited = 0;
    sAxiArAddr  = addr;
    sAxiArValid = 1'b1;
    @(negedge clk);
    while (!sAxiArReady) begin
      waited++;
      if (waited > Timeout) stopOnError("AXI read address not accepted");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    sAxiArValid = 1'b0;
    sAxiRReady  = 1'b1;
    @(negedge clk);
    while (!sAxiRValid) begin
      waited++;
      if (waited > Timeout) stopOnError("AXI read data never arrived");
      @(negedge clk);
    end
    {data, resp} = {sAxiRData, sAxiRResp};
    @(posedge clk);
    #1;
    sAxiRReady = 1'b0;
  endtask

  // first flit, then the children, then the single result
  task automatic runRow(input rowT r, input int idx);
    flitT f, exp, got;
    int   idle;
    f   = makeFlit(r, idx);
    exp = expectFor(f);
    sendFlit(f, ChildWidth'(r.children));
    for (int k = 0; k < r.children; k++) begin
      f.payload = randWord();
      f.src     = coordT'(9'(k + 1));  // children come from elsewhere
      exp.payload = foldRef(r.fn, exp.payload, f.payload);
      sendFlit(f, '0);
    end
    waitResult(1'b0, got, idle);
    if (r.children == 0) checkEq({r.name, " latency"}, 64'd3, 64'(idle));  // leaf path
    checkFlit(r.name, exp, got);
  endtask

  initial begin
    flitT        fa, fb, ea, eb, got, f;
    rowT         rowA, rowB;
    logic [31:0] data;
    logic [1:0]  resp;
    int          idle, seenA, seenB;
    rows = '{
      '{8'h01, cmbSum, collReduce,        1, coordT'(9'o123), "sumOneChild"},
      '{8'h12, cmbMax, collAllreduce,     3, coordT'(9'o701), "maxThreeChildren"},
      '{8'h23, cmbMin, collLongReduce,    5, coordT'(9'o045), "minLongReduce"},
      '{8'h34, cmbOr,  collLongAllreduce, 7, coordT'(9'o777), "orLongAllreduce"},
      '{8'h45, cmbSum, collLongReduce,    7, coordT'(9'o310), "sumSevenChildren"},
      '{8'h56, cmbMax, collReduce,        0, coordT'(9'o562), "leafReduce"},
      '{8'h67, cmbMin, collAllreduce,     2, coordT'(9'o204), "minTwoChildren"}
    };
    {inFlit, inChildren, inValid} = '0;
    outReady = 1'b1;
    {sAxiAwAddr, sAxiAwValid, sAxiWData, sAxiWStrb, sAxiWValid, sAxiBReady} = '0;
    {sAxiArAddr, sAxiArValid, sAxiRReady} = '0;
    rst = 1'b1;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;

    // coordinate register and a rejected write to a counter
    axiWrite(AddrCoord, 32'(nodeC), resp);
    checkEq("coord write resp", 64'(RespOkay), 64'(resp));
    axiWrite(AddrCompleted, 32'hffff_ffff, resp);
    checkEq("counter write resp", 64'(RespSlvErr), 64'(resp));
    axiRead(AddrCoord, data, resp);
    checkEq("coord readback", 64'(nodeC), 64'(data));
    checkEq("coord read resp", 64'(RespOkay), 64'(resp));
    axiRead(AddrCompleted, data, resp);
    checkEq("completed after bad write", 64'd0, 64'(data));
    checkEq("completed read resp", 64'(RespOkay), 64'(resp));
    axiRead(4'hc, data, resp);  // nothing mapped here
    checkEq("unmapped read resp", 64'(RespSlvErr), 64'(resp));
    checkEq("unmapped read data", 64'd0, 64'(data));

    foreach (rows[i]) runRow(rows[i], i);

    // two tags interleaved, output blocked while sending
    rowA = '{8'h0a, cmbSum, collAllreduce, 3, coordT'(9'h041), "interleaveSum"};
    rowB = '{8'h0b, cmbOr, collLongReduce, 4, coordT'(9'h102), "interleaveOr"};
    fa = makeFlit(rowA, 20);
    fb = makeFlit(rowB, 21);
    ea = expectFor(fa);
    eb = expectFor(fb);
    outReady = 1'b0;
    sendFlit(fa, 3'd3);
    sendFlit(fb, 3'd4);
    for (int k = 0; k < 4; k++) begin
      if (k < 3) begin
        fa.payload = randWord();
        ea.payload = foldRef(rowA.fn, ea.payload, fa.payload);
        sendFlit(fa, '0);
      end
      fb.payload = randWord();
      eb.payload = foldRef(rowB.fn, eb.payload, fb.payload);
      sendFlit(fb, '0);
    end
    seenA = 0;
    seenB = 0;
    repeat (2) begin
      waitResult(1'b1, got, idle);  // drain under random stalls
      if (got.tag == rowA.tag) begin
        seenA++;
        checkFlit(rowA.name, ea, got);
      end else begin
        seenB++;
        checkFlit(rowB.name, eb, got);
      end
    end
    checkEq("interleaveSum count", 64'd1, 64'(seenA));
    checkEq("interleaveOr count", 64'd1, 64'(seenB));
    expectQuiet(20);

    // gathers and an invalid flit are all dropped
    for (int k = 0; k < 4; k++) begin
      f = makeFlit(rows[k], 30 + k);
      f.op = (k % 2) ? collGather : collAllgather;
      if (k == 3) begin
        f.op    = collReduce;
        f.valid = 1'b0;  // reduce op but not a live flit
      end
      sendFlit(f, 3'd2);
    end
    expectQuiet(20);
    axiRead(AddrCompleted, data, resp);
    checkEq("completed count", 64'd9, 64'(data));
    checkEq("completed count resp", 64'(RespOkay), 64'(resp));
    axiRead(AddrDropped, data, resp);
    checkEq("dropped count", 64'd4, 64'(data));
    checkEq("dropped count resp", 64'(RespOkay), 64'(resp));

    $display("Simulation passed");
    $finish;
  end

endmodule
